// ==== tb.f ====
+incdir+include
src/trig_csr_pkg.sv
src/trig_core_pkg.sv
src/tdata_warl.sv
src/trigger_bank.sv
src/trigger_match.sv
src/debug_triggers.sv
dv/tb_debug_triggers.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the debug trigger testbench with Verilator.
# Exit status is non-zero when the testbench stops with $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_debug_triggers \
  -o sim_tb_debug_triggers

./obj_dir/sim_tb_debug_triggers

// ==== include/tb_model.svh ====
/*
  Reference model for the debug trigger testbench
  Included inside the testbench module after the package imports. Gives the
  stimulus LFSR, the tdata1 WARL rule and the expected hit vector
*/
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32 bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Expected stored tdata1 for a written word
function automatic logic [31:0] model_tdata1(input logic [31:0] w);
  logic [31:0] r;
  logic [3:0]  m;
  r = TDATA1_RST_VAL;
  m = w[MCONTROL6_MATCH_HIGH:MCONTROL6_MATCH_LOW];
  if (w[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_MCONTROL6) begin
    r = '0;
    r[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] = TTYPE_MCONTROL6;
    r[27] = 1'b1;  // dmode
    r[12] = 1'b1;  // action, enter debug
    r[MCONTROL6_MATCH_HIGH:MCONTROL6_MATCH_LOW] =
      (m == MATCH_EQ || m == MATCH_GE || m == MATCH_LT) ? m : MATCH_EQ;
    r[MCONTROL6_M]       = w[MCONTROL6_M];
    r[MCONTROL6_U]       = w[MCONTROL6_U];
    r[MCONTROL6_EXECUTE] = w[MCONTROL6_EXECUTE];
    r[MCONTROL6_STORE]   = w[MCONTROL6_STORE];
    r[MCONTROL6_LOAD]    = w[MCONTROL6_LOAD];
  end
  return r;
endfunction

// Expected hits from the shadow tdata1/tdata2 copies
function automatic trig_hit_t model_hit(
  input logic [NUM_TRIGGERS-1:0][31:0] t1,
  input logic [NUM_TRIGGERS-1:0][31:0] t2,
  input fetch_req_t f,
  input lsu_req_t   l,
  input logic       dbg
);
  trig_hit_t   h;
  logic [3:0]  kind;
  logic        on, arm_f, arm_l, dir, eq_byte;
  logic [31:0] lo, hi;
  h  = '0;
  lo = {l.addr[31:2], 2'b00};
  hi = lo;
  for (int b = 0; b < 4; b++) if (l.be[b]) hi[1:0] = 2'(b);
  for (int b = 3; b >= 0; b--) if (l.be[b]) lo[1:0] = 2'(b);
  for (int i = 0; i < NUM_TRIGGERS; i++) begin
    kind  = t1[i][MCONTROL6_MATCH_HIGH:MCONTROL6_MATCH_LOW];
    on    = !dbg && (t1[i][TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_MCONTROL6);
    arm_f = on && ((t1[i][MCONTROL6_M] && f.priv == PRIV_LVL_M) ||
                   (t1[i][MCONTROL6_U] && f.priv == PRIV_LVL_U));
    arm_l = on && ((t1[i][MCONTROL6_M] && l.priv == PRIV_LVL_M) ||
                   (t1[i][MCONTROL6_U] && l.priv == PRIV_LVL_U));
    dir   = (t1[i][MCONTROL6_LOAD] && !l.we) || (t1[i][MCONTROL6_STORE] && l.we);
    eq_byte = |(l.be & (4'b0001 << t2[i][1:0]));
    if (arm_f && t1[i][MCONTROL6_EXECUTE]) begin
      h.fetch |= (kind == MATCH_EQ) ? (f.pc == t2[i]) :
                 (kind == MATCH_GE) ? (f.pc >= t2[i]) : (f.pc < t2[i]);
    end
    if (arm_l && l.valid && dir) begin
      h.lsu |= (kind == MATCH_EQ) ? ((l.addr[31:2] == t2[i][31:2]) && eq_byte) :
               (kind == MATCH_GE) ? (hi >= t2[i]) : (lo < t2[i]);
    end
  end
  return h;
endfunction

`endif

// ==== dv/tb_debug_triggers.sv ====
/*
  Testbench for the debug trigger unit
  Drives CSR writes, fetch and load/store traffic from a fixed-seed LFSR,
  keeps a shadow copy of the trigger CSRs and compares read data and hits
  against the reference model on every falling clock edge
*/
`timescale 1ns/10ps

module tb_debug_triggers
  import trig_csr_pkg::*;
  import trig_core_pkg::*;
;

  `include "tb_model.svh"

  //////////////////////////////////////////////////
  // Run length
  //////////////////////////////////////////////////
  localparam logic [31:0] LFSR_SEED = 32'ha4ae_e8f6;
  localparam int RST_CYCLES  = 16;
  localparam int IDLE_CYCLES = 20;  // Traffic right after reset
  localparam int N_TSEL      = 16;  // tselect write rounds
  localparam int N_T1        = 32;  // Random tdata1 words
  localparam int N_CFG       = 64;  // Config plus traffic rounds
  localparam int N_TRAFFIC   = 8;   // Traffic cycles per round
  localparam int DBG_CYCLES  = 32;  // Traffic with debug mode forced
  localparam int TEST_CYCLES = RST_CYCLES + IDLE_CYCLES + N_TSEL * 4 + N_T1 * 4 +
                               N_CFG * (6 + N_TRAFFIC) + NUM_TRIGGERS * 6 +
                               DBG_CYCLES + 4;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic       clk;
  logic       rst_n_i;
  csr_wr_t    csr_wr_i;
  fetch_req_t fetch_i;
  lsu_req_t   lsu_i;
  logic       debug_mode_i;
  csr_rd_t    csr_rd_o;
  trig_hit_t  hit_o;

  logic [31:0]                   seed_q;     // LFSR state
  int                            cycle_cnt;  // Timeout counter
  int                            n_checks;   // Compares done so far
  logic [31:0]                   sh_tsel;    // Shadow tselect
  logic [NUM_TRIGGERS-1:0][31:0] sh_t1;      // Shadow tdata1 per trigger
  logic [NUM_TRIGGERS-1:0][31:0] sh_t2;      // Shadow tdata2 per trigger
  trig_hit_t                     exp_hit;

  debug_triggers dut (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .csr_wr_i     (csr_wr_i),
    .fetch_i      (fetch_i),
    .lsu_i        (lsu_i),
    .debug_mode_i (debug_mode_i),
    .csr_rd_o     (csr_rd_o),
    .hit_o        (hit_o)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Takes n bits with one LFSR step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      seed_q = lfsr_next(seed_q);
      r      = {r[30:0], seed_q[31]};
    end
    return r;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////
  // One strobe cycle and then the strobes drop
  task automatic write_csr(input logic [31:0] data, input logic sel_we,
                           input logic t1_we, input logic t2_we);
    @(posedge clk);
    csr_wr_i <= {data, sel_we, t1_we, t2_we};
    @(posedge clk);
    csr_wr_i <= {data, 3'b000};
  endtask

  // One cycle of traffic around a stored tdata2
  task automatic drive_traffic(input logic dbg_force);
    logic [31:0] r;
    logic [31:0] base;
    logic [31:0] pc;
    logic [31:0] addr;
    r    = rand_bits(1);
    base = sh_t2[r[0]];                                      // Aim at one trigger
    r    = rand_bits(5);
    pc   = (r[4:3] == 2'b00) ? rand_bits(32) : base + {{29{r[2]}}, r[2:0]};
    r    = rand_bits(5);
    addr = (r[4:3] == 2'b00) ? rand_bits(32) : base + {{29{r[2]}}, r[2:0]};
    @(posedge clk);
    fetch_i <= '{pc: pc, priv: rand_bits(1) ? PRIV_LVL_M : PRIV_LVL_U};
    r = rand_bits(11);
    lsu_i   <= '{valid: |r[1:0], addr: addr, we: r[2], be: r[6:3],
                 priv: r[7] ? PRIV_LVL_M : PRIV_LVL_U};
    debug_mode_i <= dbg_force || (r[10:8] == 3'b000);         // Debug now and then
  endtask

  // Random mcontrol6 setup of one trigger
  task automatic configure_trigger();
    logic [31:0] r;
    logic [31:0] word;
    r = rand_bits(1);
    write_csr(r, 1'b1, 1'b0, 1'b0);
    word = rand_bits(32);
    r    = rand_bits(5);
    if (r[2:0] != 3'b000) word[31:28] = TTYPE_MCONTROL6;       // Mostly armed types
    case (r[4:3])
      2'd0: word[10:7] = MATCH_EQ;
      2'd1: word[10:7] = MATCH_GE;
      2'd2: word[10:7] = MATCH_LT;
      default: ;                                               // Raw nibble that may be illegal
    endcase
    write_csr(word, 1'b0, 1'b1, 1'b0);
    write_csr(rand_bits(32), 1'b0, 1'b0, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst_n_i) begin
      sh_tsel = '0;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        sh_t1[i] = TDATA1_RST_VAL;
        sh_t2[i] = '0;
      end
    end else begin
      check_val(csr_rd_o.tselect, sh_tsel, "tselect read");
      check_val(csr_rd_o.tdata1, sh_t1[sh_tsel[0]], "tdata1 read");
      check_val(csr_rd_o.tdata2, sh_t2[sh_tsel[0]], "tdata2 read");
      exp_hit = model_hit(sh_t1, sh_t2, fetch_i, lsu_i, debug_mode_i);
      check_val({30'd0, hit_o}, {30'd0, exp_hit}, "hit vector");
      // Strobes on the wires now land at the next rising edge
      if (csr_wr_i.tdata1_we) sh_t1[sh_tsel[0]] = model_tdata1(csr_wr_i.wdata);
      if (csr_wr_i.tdata2_we) sh_t2[sh_tsel[0]] = csr_wr_i.wdata;
      if (csr_wr_i.tselect_we && csr_wr_i.wdata < NUM_TRIGGERS) sh_tsel = csr_wr_i.wdata;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("STATUS: FAIL");
      $fatal(1, "Simulation ran past its cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    csr_wr_i     = '0;
    fetch_i      = '{pc: 32'd0, priv: PRIV_LVL_M};
    lsu_i        = '{valid: 1'b0, addr: 32'd0, we: 1'b0, be: 4'd0, priv: PRIV_LVL_M};
    debug_mode_i = 1'b0;
    seed_q       = LFSR_SEED;
    cycle_cnt    = 0;
    n_checks     = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;

    // Disabled triggers stay quiet after reset
    repeat (IDLE_CYCLES) drive_traffic(1'b0);

    // tselect WARL with tdata2 of the same cycle going to the old selection
    for (int n = 0; n < N_TSEL; n++) begin
      write_csr(rand_bits(1) ? rand_bits(32) : rand_bits(2), 1'b1, 1'b0, rand_bits(1) == 1);
      write_csr(rand_bits(32), 1'b0, 1'b0, 1'b1);
    end

    // Random tdata1 words with half of them type 6
    for (int n = 0; n < N_T1; n++) begin
      logic [31:0] w;
      write_csr(rand_bits(1), 1'b1, 1'b0, 1'b0);
      w = rand_bits(32);
      if (rand_bits(1) == 1) w[31:28] = TTYPE_MCONTROL6;
      write_csr(w, 1'b0, 1'b1, 1'b0);
    end

    // Fetch and load/store matches around tdata2
    for (int n = 0; n < N_CFG; n++) begin
      configure_trigger();
      repeat (N_TRAFFIC) drive_traffic(1'b0);
    end

    // Both triggers fire on anything and debug mode must mask them
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      write_csr(i, 1'b1, 1'b0, 1'b0);
      write_csr(32'h6000_014F, 1'b0, 1'b1, 1'b0);  // GE, M, U, execute, store, load
      write_csr(32'd0, 1'b0, 1'b0, 1'b1);
    end
    repeat (DBG_CYCLES) drive_traffic(1'b1);

    @(posedge clk);
    debug_mode_i <= 1'b0;
    lsu_i.valid  <= 1'b0;
    repeat (2) @(posedge clk);
    if (n_checks > 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "No comparisons were made");
    end
  end

endmodule

// ==== src/debug_triggers.sv ====
/*
  Debug trigger unit, top level
  CSR writes pass the WARL legalizer into the register bank; the bank feeds
  read data out and the stored config to the match unit. hit_o is a level,
  combinational from the requests and the stored config
*/
`timescale 1ns/10ps

module debug_triggers
  import trig_csr_pkg::*;
  import trig_core_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  csr_wr_t    csr_wr_i,      // tselect/tdata1/tdata2 write strobes
  input  fetch_req_t fetch_i,       // Fetch stage pc and privilege
  input  lsu_req_t   lsu_i,         // Execute stage load/store
  input  logic       debug_mode_i,
  output csr_rd_t    csr_rd_o,      // Read back of the selected trigger
  output trig_hit_t  hit_o          // Fetch and load/store hits
);

  csr_upd_t                     upd;  // Legalized updates
  trig_cfg_t [NUM_TRIGGERS-1:0] cfg;  // Stored trigger config

  //////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////
  tdata_warl u_warl (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .csr_wr_i (csr_wr_i),
    .upd_o    (upd)
  );

  trigger_bank u_bank (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .upd_i   (upd),
    .cfg_o   (cfg),
    .rd_o    (csr_rd_o)
  );

  //////////////////////////////////////////////////
  // Match path
  //////////////////////////////////////////////////
  trigger_match u_match (
    .fetch_i      (fetch_i),
    .lsu_i        (lsu_i),
    .debug_mode_i (debug_mode_i),
    .cfg_i        (cfg),
    .hit_o        (hit_o)
  );

endmodule

// ==== src/trigger_match.sv ====
/*
  Trigger match unit
  Compares the fetch pc and the load/store address against every trigger
  and ORs the per trigger hits. Purely combinational, zero latency
*/
`timescale 1ns/10ps

module trigger_match
  import trig_csr_pkg::*;
  import trig_core_pkg::*;
(
  input  fetch_req_t                   fetch_i,       // Fetch stage
  input  lsu_req_t                     lsu_i,         // Execute stage
  input  logic                         debug_mode_i,  // Core in debug mode
  input  trig_cfg_t [NUM_TRIGGERS-1:0] cfg_i,         // Stored config
  output trig_hit_t                    hit_o
);

  logic [1:0]              lsu_low_lsb;   // Offset of lowest enabled byte
  logic [1:0]              lsu_high_lsb;  // Offset of highest enabled byte
  logic [31:0]             lsu_addr_low;
  logic [31:0]             lsu_addr_high;
  logic [NUM_TRIGGERS-1:0] fetch_hit;
  logic [NUM_TRIGGERS-1:0] lsu_hit;

  //////////////////////////////////////////////////
  // Accessed byte range
  //////////////////////////////////////////////////
  always_comb begin
    lsu_low_lsb  = 2'b00;
    lsu_high_lsb = 2'b00;
    for (int b = 0; b < 4; b++) begin
      if (lsu_i.be[b]) lsu_high_lsb = 2'(b);  // Last set bit wins
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_i.be[b]) lsu_low_lsb = 2'(b);   // First set bit wins
    end
  end

  assign lsu_addr_low  = {lsu_i.addr[31:2], lsu_low_lsb};
  assign lsu_addr_high = {lsu_i.addr[31:2], lsu_high_lsb};

  //////////////////////////////////////////////////
  // Per trigger compare
  //////////////////////////////////////////////////
  for (genvar idx = 0; idx < NUM_TRIGGERS; idx++) begin : gen_match
    tdata1_u     t1;           // Control word, mcontrol6 view
    logic [31:0] t2;           // Compare value
    logic        active;       // mcontrol6 and outside debug mode
    logic        armed_if;
    logic        armed_ex;
    logic        if_match;
    logic [3:0]  byte_match;   // Enabled byte sits at tdata2[1:0]
    logic        lsu_dir_en;   // Direction enabled
    logic        lsu_match;

    assign t1 = cfg_i[idx].tdata1;
    assign t2 = cfg_i[idx].tdata2;

    assign active   = (t1.mc6.ttype == TTYPE_MCONTROL6) && !debug_mode_i;
    assign armed_if = active && ((t1.mc6.m && (fetch_i.priv == PRIV_LVL_M)) ||
                                 (t1.mc6.u && (fetch_i.priv == PRIV_LVL_U)));
    assign armed_ex = active && ((t1.mc6.m && (lsu_i.priv == PRIV_LVL_M)) ||
                                 (t1.mc6.u && (lsu_i.priv == PRIV_LVL_U)));

    // Fetch address compare
    assign if_match = (t1.mc6.match == MATCH_EQ) ? (fetch_i.pc == t2) :
                      (t1.mc6.match == MATCH_GE) ? (fetch_i.pc >= t2) :
                                                   (fetch_i.pc <  t2);

    always_comb begin
      for (int b = 0; b < 4; b++) begin
        byte_match[b] = lsu_i.be[b] && (2'(b) == t2[1:0]);
      end
    end

    // EQ needs same word and a hit byte, GE/LT use the byte range ends
    assign lsu_match = (t1.mc6.match == MATCH_EQ) ?
                         ((lsu_i.addr[31:2] == t2[31:2]) && (|byte_match)) :
                       (t1.mc6.match == MATCH_GE) ? (lsu_addr_high >= t2) :
                                                    (lsu_addr_low  <  t2);

    assign lsu_dir_en = (t1.mc6.load && !lsu_i.we) || (t1.mc6.store && lsu_i.we);

    assign fetch_hit[idx] = armed_if && t1.mc6.execute && if_match;
    assign lsu_hit[idx]   = armed_ex && lsu_i.valid && lsu_dir_en && lsu_match;
  end

  assign hit_o.fetch = |fetch_hit;
  assign hit_o.lsu   = |lsu_hit;

  // Debug mode must silence both outputs
  always_comb begin
    if (debug_mode_i) begin
      a_no_hit_in_debug: assert (hit_o == '0)
        else $error("Trigger hit while in debug mode");
    end
  end

endmodule

// ==== src/trigger_bank.sv ====
/*
  Trigger register bank
  Holds tselect and the tdata1/tdata2 pair of every trigger. Updates land on
  the clock edge of the strobe; read data of the selected trigger is a
  combinational mux of the stored registers
*/
`timescale 1ns/10ps

module trigger_bank
  import trig_csr_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  csr_upd_t                     upd_i,  // Legalized updates
  output trig_cfg_t [NUM_TRIGGERS-1:0] cfg_o,  // Stored config to match unit
  output csr_rd_t                      rd_o    // CSR read data
);

  logic [XLEN-1:0] tselect_q;                 // Selected trigger index
  tdata1_u         tdata1_q [NUM_TRIGGERS];   // Control words
  logic [XLEN-1:0] tdata2_q [NUM_TRIGGERS];   // Compare values

  //////////////////////////////////////////////////
  // tselect
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (upd_i.tselect_we) begin
      tselect_q <= upd_i.tselect;
    end
  end

  //////////////////////////////////////////////////
  // Per trigger registers
  //////////////////////////////////////////////////
  for (genvar idx = 0; idx < NUM_TRIGGERS; idx++) begin : gen_trig
    logic sel;  // This trigger is addressed by the old tselect

    assign sel = (tselect_q == XLEN'(idx));

    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        tdata1_q[idx] <= TDATA1_RST_VAL;
        tdata2_q[idx] <= '0;
      end else begin
        if (upd_i.tdata1_we && sel) begin
          tdata1_q[idx] <= upd_i.tdata1;
        end
        if (upd_i.tdata2_we && sel) begin
          tdata2_q[idx] <= upd_i.tdata2;
        end
      end
    end

    assign cfg_o[idx].tdata1 = tdata1_q[idx];
    assign cfg_o[idx].tdata2 = tdata2_q[idx];

    // Bank never holds a type the match unit does not know
    a_stored_type: assert property (@(posedge clk) disable iff (!rst_n_i)
      (tdata1_q[idx].generic.ttype == TTYPE_MCONTROL6) ||
      (tdata1_q[idx].generic.ttype == TTYPE_DISABLED))
      else $error("Trigger %0d holds illegal type", idx);
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////
  always_comb begin
    rd_o.tselect = tselect_q;
    rd_o.tdata1  = tdata1_q[0];  // Default, tselect is always in range
    rd_o.tdata2  = tdata2_q[0];
    for (int i = 1; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == XLEN'(i)) begin
        rd_o.tdata1 = tdata1_q[i];
        rd_o.tdata2 = tdata2_q[i];
      end
    end
  end

  // Legalizer filters every tselect write
  a_tsel_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    tselect_q < XLEN'(NUM_TRIGGERS))
    else $error("tselect out of range");

endmodule

// ==== src/tdata_warl.sv ====
/*
  WARL legalizer for the trigger CSRs
  Turns raw write data and strobes into register updates for the trigger
  bank. Purely combinational; clk and rst_n_i only clock the checks
*/
`timescale 1ns/10ps

module tdata_warl
  import trig_csr_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  csr_wr_t  csr_wr_i,  // Raw CSR write
  output csr_upd_t upd_o      // Legalized update
);

  tdata1_u    wr_word;   // Incoming word, type read through generic view
  tdata1_u    leg_word;  // Legal tdata1 value
  logic [3:0] wr_match;  // Requested match kind
  logic       match_ok;  // Kind is implemented

  assign wr_word  = csr_wr_i.wdata;
  assign wr_match = csr_wr_i.wdata[MCONTROL6_MATCH_HIGH:MCONTROL6_MATCH_LOW];
  assign match_ok = (wr_match == MATCH_EQ) || (wr_match == MATCH_GE) ||
                    (wr_match == MATCH_LT);

  //////////////////////////////////////////////////
  // tdata1 legalization
  //////////////////////////////////////////////////
  always_comb begin
    leg_word = TDATA1_RST_VAL;  // Unknown type falls back to disabled
    if (wr_word.generic.ttype == TTYPE_MCONTROL6) begin
      leg_word            = '0;               // Unimplemented fields read zero
      leg_word.mc6.ttype  = TTYPE_MCONTROL6;
      leg_word.mc6.dmode  = 1'b1;             // Debug mode owns the trigger
      leg_word.mc6.action = 4'h1;             // Enter debug on hit
      leg_word.mc6.match  = match_ok ? wr_match : MATCH_EQ;
      // Enables keep their wdata positions
      leg_word.mc6.m       = csr_wr_i.wdata[MCONTROL6_M];
      leg_word.mc6.u       = csr_wr_i.wdata[MCONTROL6_U];
      leg_word.mc6.execute = csr_wr_i.wdata[MCONTROL6_EXECUTE];
      leg_word.mc6.store   = csr_wr_i.wdata[MCONTROL6_STORE];
      leg_word.mc6.load    = csr_wr_i.wdata[MCONTROL6_LOAD];
    end
  end

  //////////////////////////////////////////////////
  // Update outputs
  //////////////////////////////////////////////////
  assign upd_o.tselect    = csr_wr_i.wdata;
  // Out of range index is ignored, bank keeps old tselect
  assign upd_o.tselect_we = csr_wr_i.tselect_we &&
                            (csr_wr_i.wdata < XLEN'(NUM_TRIGGERS));

  assign upd_o.tdata1    = leg_word;
  assign upd_o.tdata1_we = csr_wr_i.tdata1_we;

  assign upd_o.tdata2    = csr_wr_i.wdata;      // Any compare value is legal
  assign upd_o.tdata2_we = csr_wr_i.tdata2_we;

  // Only the two implemented types ever reach the bank
  a_leg_type: assert property (@(posedge clk) disable iff (!rst_n_i)
    (upd_o.tdata1.generic.ttype == TTYPE_MCONTROL6) ||
    (upd_o.tdata1.generic.ttype == TTYPE_DISABLED))
    else $error("Legalized tdata1 has illegal type");

endmodule

// ==== src/trig_core_pkg.sv ====
/*
  Pipeline side types of the debug trigger unit
  Privilege level, the fetch and load/store requests that are checked, and
  the hit vector returned to the core
*/
package trig_core_pkg;

  // Privilege levels supported by the core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Fetch stage request
  typedef struct packed {
    logic [31:0] pc;    // Address of the fetched instruction
    priv_lvl_e   priv;
  } fetch_req_t;

  // Execute stage load/store request
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;  // Word address plus byte offset
    logic        we;    // High for store
    logic [3:0]  be;    // Byte enables within the word
    priv_lvl_e   priv;
  } lsu_req_t;

  // Level hits, OR of all triggers
  typedef struct packed {
    logic fetch;  // Instruction address match
    logic lsu;    // Load/store address match
  } trig_hit_t;

endpackage

// ==== src/trig_csr_pkg.sv ====
/*
  Trigger CSR layout for the debug trigger unit
  Holds the tdata1 encodings, the bit positions used by the WARL logic and
  the match unit, and the structs that carry CSR writes, updates and reads
  Import with trig_csr_pkg::* where any of these are needed
*/
package trig_csr_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int NUM_TRIGGERS = 2;   // Triggers in the bank
  localparam int XLEN         = 32;  // CSR and address width

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////
  localparam logic [3:0] TTYPE_MCONTROL6 = 4'h6;  // Address match trigger
  localparam logic [3:0] TTYPE_DISABLED  = 4'hF;  // Trigger off

  localparam logic [3:0] MATCH_EQ = 4'h0;  // Address equal
  localparam logic [3:0] MATCH_GE = 4'h2;  // Address >= tdata2
  localparam logic [3:0] MATCH_LT = 4'h3;  // Address < tdata2

  localparam logic [XLEN-1:0] TDATA1_RST_VAL = 32'hF800_0000;  // Disabled, dmode set

  // Field positions inside tdata1
  localparam int TDATA1_TTYPE_HIGH    = 31;
  localparam int TDATA1_TTYPE_LOW     = 28;
  localparam int MCONTROL6_MATCH_HIGH = 10;
  localparam int MCONTROL6_MATCH_LOW  = 7;
  localparam int MCONTROL6_M          = 6;
  localparam int MCONTROL6_U          = 3;
  localparam int MCONTROL6_EXECUTE    = 2;
  localparam int MCONTROL6_STORE      = 1;
  localparam int MCONTROL6_LOAD       = 0;

  //////////////////////////////////////////////////
  // tdata1 word, seen two ways
  //////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [3:0]  ttype;  // Trigger type
      logic        dmode;  // Writable from debug mode only
      logic [26:0] body;   // Type specific
    } generic;
    struct packed {
      logic [3:0] ttype;
      logic       dmode;
      logic [1:0] zero_26_25;
      logic       vs;
      logic       vu;
      logic       hit;
      logic       select;   // Address only, tied low
      logic       timing;   // Before timing only
      logic [3:0] size;     // Any size
      logic [3:0] action;   // 1 means enter debug
      logic       chain;
      logic [3:0] match;    // EQ, GE or LT
      logic       m;        // Machine mode enable
      logic       zero_5;
      logic       s;
      logic       u;        // User mode enable
      logic       execute;  // Instruction address match
      logic       store;
      logic       load;
    } mc6;
  } tdata1_u;

  // Stored configuration of one trigger
  typedef struct packed {
    tdata1_u           tdata1;
    logic [XLEN-1:0]   tdata2;  // Compare value
  } trig_cfg_t;

  // Raw CSR write port, strobes share wdata
  typedef struct packed {
    logic [XLEN-1:0] wdata;
    logic            tselect_we;
    logic            tdata1_we;
    logic            tdata2_we;
  } csr_wr_t;

  // Legalized register updates
  typedef struct packed {
    logic [XLEN-1:0] tselect;
    tdata1_u         tdata1;
    logic [XLEN-1:0] tdata2;
    logic            tselect_we;
    logic            tdata1_we;
    logic            tdata2_we;
  } csr_upd_t;

  // Read data of the selected trigger
  typedef struct packed {
    logic [XLEN-1:0] tselect;
    logic [XLEN-1:0] tdata1;
    logic [XLEN-1:0] tdata2;
  } csr_rd_t;

endpackage
